// File: dv/mem_subsys_tb.sv
`timescale 1ns/100ps
`include "brisc_cfg.svh"

module mem_subsys_tb;

  localparam int N_FETCH = 24;
  localparam int N_DATA = 40;
  localparam int N_EVICT = 6;
  localparam int N_ROUNDS = 32;
  localparam int N_TRANS = 2 * N_FETCH + 3 * N_DATA + 4 * N_EVICT + 5 * N_ROUNDS;
  localparam int CYCLE_LIMIT = 40 * N_TRANS + 200;
  localparam int PORT_WAIT = 40; // cycles per transaction

  logic clk;
  logic rst_n;
  logic if_req;
  logic [`BRISC_ADDR_W-1:0] if_addr;
  logic if_valid;
  logic [`BRISC_XLEN-1:0] if_rdata;
  logic d_req;
  logic d_we;
  logic [`BRISC_XLEN/8-1:0] d_be;
  logic [`BRISC_ADDR_W-1:0] d_addr;
  logic [`BRISC_XLEN-1:0] d_wdata;
  logic d_valid;
  logic [`BRISC_XLEN-1:0] d_rdata;

  logic [7:0] ref_mem [1 << `BRISC_ADDR_W]; // byte-wide reference memory
  logic [31:0] rand_state;
  int data_errors = 0;
  int proto_errors = 0;
  int timeout_errors = 0;
  int cycle_cnt = 0;
  bit ifetch_hung = 1'b0;
  bit data_hung = 1'b0;

  mem_subsys mem_subsys_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .if_req  (if_req),
    .if_addr (if_addr),
    .if_valid(if_valid),
    .if_rdata(if_rdata),
    .d_req   (d_req),
    .d_we    (d_we),
    .d_be    (d_be),
    .d_addr  (d_addr),
    .d_wdata (d_wdata),
    .d_valid (d_valid),
    .d_rdata (d_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // one valid per accepted request, and only while the request is held
  ifetch_single_valid: assert property (@(posedge clk) disable iff (!rst_n)
    if_valid |=> !if_valid) else begin
    proto_errors++;
    $display("instruction port gave a second valid before a new request");
  end
  ifetch_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    if_valid |-> if_req) else begin
    proto_errors++;
    $display("instruction port gave a valid with no request pending");
  end
  data_single_valid: assert property (@(posedge clk) disable iff (!rst_n)
    d_valid |=> !d_valid) else begin
    proto_errors++;
    $display("data port gave a second valid before a new request");
  end
  data_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    d_valid |-> d_req) else begin
    proto_errors++;
    $display("data port gave a valid with no request pending");
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic [31:0] model_word(input logic [`BRISC_ADDR_W-1:0] addr);
    logic [`BRISC_ADDR_W-3:0] wa;
    wa = addr[`BRISC_ADDR_W-1:2];
    return {ref_mem[{wa, 2'd3}], ref_mem[{wa, 2'd2}], ref_mem[{wa, 2'd1}], ref_mem[{wa, 2'd0}]};
  endfunction

  function automatic logic [`BRISC_ADDR_W-1:0] inst_addr(input logic [31:0] r);
    return {1'b0, r[10:2], 2'b00}; // 0x000 to 0x7fc
  endfunction

  function automatic logic [`BRISC_ADDR_W-1:0] data_addr(input logic [31:0] r);
    return {1'b1, r[10:2], 2'b00}; // 0x800 to 0xffc
  endfunction

  task automatic fetch_word(input logic [`BRISC_ADDR_W-1:0] addr, input bit expect_hit);
    int waited;
    logic [31:0] exp_word;
    begin
      @(posedge clk);
      if_req <= 1'b1;
      if_addr <= addr;
      waited = 0;
      @(negedge clk);
      while (!if_valid && waited < PORT_WAIT) begin
        @(negedge clk);
        waited++;
      end
      if (!if_valid) begin
        timeout_errors++;
        ifetch_hung = 1'b1;
        $display("instruction port hung, no if_valid within %0d cycles at %h", PORT_WAIT, addr);
      end else begin
        exp_word = model_word(addr);
        fetch_value: assert (if_rdata == exp_word) else begin
          data_errors++;
          $display("MISMATCH if_rdata at %h: expected %h, got %h", addr, exp_word, if_rdata);
        end
        if (expect_hit) begin
          fetch_hit_time: assert (waited == 1) else begin
            proto_errors++;
            $display("fetch hit at %h took %0d cycles instead of 1", addr, waited);
          end
        end
      end
    end
  endtask

  task automatic data_access(input bit we, input logic [3:0] be,
                             input logic [`BRISC_ADDR_W-1:0] addr,
                             input logic [31:0] wdata, input bit expect_hit);
    int waited;
    logic [31:0] exp_word;
    begin
      @(posedge clk);
      d_req <= 1'b1;
      d_we <= we;
      d_be <= be;
      d_addr <= addr;
      d_wdata <= wdata;
      waited = 0;
      @(negedge clk);
      while (!d_valid && waited < PORT_WAIT) begin
        @(negedge clk);
        waited++;
      end
      if (!d_valid) begin
        timeout_errors++;
        data_hung = 1'b1;
        $display("data port hung, no d_valid within %0d cycles at %h", PORT_WAIT, addr);
      end else begin
        if (expect_hit) begin
          data_hit_time: assert (waited == 1) else begin
            proto_errors++;
            $display("data hit at %h took %0d cycles instead of 1", addr, waited);
          end
        end
        if (we) begin
          for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
              ref_mem[{addr[`BRISC_ADDR_W-1:2], 2'(b)}] = wdata[8*b +: 8];
            end
          end
        end else begin
          exp_word = model_word(addr);
          load_value: assert (d_rdata == exp_word) else begin
            data_errors++;
            $display("MISMATCH d_rdata at %h: expected %h, got %h", addr, exp_word, d_rdata);
          end
        end
      end
    end
  endtask

  task automatic release_ports;
    @(posedge clk);
    if_req <= 1'b0;
    d_req <= 1'b0;
    d_we <= 1'b0;
  endtask

  task automatic finish_run;
    $display("errors: data %0d, protocol %0d, timeout %0d",
             data_errors, proto_errors, timeout_errors);
    if (data_errors + proto_errors + timeout_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  initial begin
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    timeout_errors++;
    $display("run did not finish within %0d cycles", CYCLE_LIMIT);
    finish_run();
  end

  initial begin
    logic [31:0] r;
    logic [`BRISC_ADDR_W-1:0] a;
    logic [`BRISC_ADDR_W-1:0] b;
    rst_n = 1'b0;
    if_req = 1'b0;
    if_addr = '0;
    d_req = 1'b0;
    d_we = 1'b0;
    d_be = '0;
    d_addr = '0;
    d_wdata = '0;
    rand_state = 32'hf262994f;
    for (int i = 0; i < (1 << `BRISC_ADDR_W); i++) begin
      ref_mem[i] = 8'h00;
    end

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    reset_idle: assert (!if_valid && !d_valid) else begin
      proto_errors++;
      $display("a valid was high right after reset release");
    end

    // fetch misses, then the same address again as a hit
    for (int i = 0; i < N_FETCH && !ifetch_hung; i++) begin
      a = inst_addr(next_rand());
      fetch_word(a, 1'b0);
      fetch_word(a, 1'b1);
    end
    release_ports();

    // partial stores, load back as a hit, then a random load
    for (int i = 0; i < N_DATA && !data_hung; i++) begin
      r = next_rand();
      a = data_addr(next_rand());
      data_access(1'b1, r[3:0], a, next_rand(), 1'b0);
      data_access(1'b0, 4'h0, a, '0, 1'b1);
      data_access(1'b0, 4'h0, data_addr(next_rand()), '0, 1'b0);
    end
    release_ports();

    // same index, other tag, so each access evicts a dirty line
    for (int i = 0; i < N_EVICT && !data_hung; i++) begin
      a = data_addr(next_rand());
      b = a ^ 12'h200;
      data_access(1'b1, 4'hf, a, next_rand(), 1'b0);
      data_access(1'b1, 4'hf, b, next_rand(), 1'b0);
      data_access(1'b0, 4'h0, a, '0, 1'b0);
      data_access(1'b0, 4'h0, b, '0, 1'b0);
    end
    release_ports();

    fork
      begin
        for (int i = 0; i < N_ROUNDS && !ifetch_hung; i++) begin
          a = inst_addr(next_rand());
          fetch_word(a, 1'b0);
          fetch_word(a, 1'b1);
        end
        @(posedge clk);
        if_req <= 1'b0; // a held request would be taken again
      end
      begin
        for (int i = 0; i < N_ROUNDS && !data_hung; i++) begin
          r = next_rand();
          b = data_addr(next_rand());
          data_access(1'b1, r[7:4], b, next_rand(), 1'b0);
          data_access(1'b0, 4'h0, b, '0, 1'b1);
          data_access(1'b0, 4'h0, data_addr(next_rand()), '0, 1'b0);
        end
        @(posedge clk);
        d_req <= 1'b0;
        d_we <= 1'b0;
      end
    join

    repeat (4) @(posedge clk);
    finish_run();
  end

endmodule

// File: include/brisc_cfg.svh
`ifndef BRISC_CFG_SVH
`define BRISC_CFG_SVH

// core word and address space
`define BRISC_XLEN 32
`define BRISC_ADDR_W 12

// line geometry
`define BRISC_LINE_WORDS 4
`define BRISC_LINE_W 128

`define BRISC_MEM_DEPTH 1024 // words
`define BRISC_CACHE_LINES 8

// main memory pipes and flow control
`define BRISC_MEM_REQ_DELAY 3
`define BRISC_MEM_RESP_DELAY 4
`define BRISC_MEM_CREDITS 2

`endif

// File: rtl/brisc_pkg.sv
`include "brisc_cfg.svh"

package brisc_pkg;

  // one cache line, seen as words for fetch and load
  // and as bytes for the store merge
  typedef union packed {
    logic [`BRISC_LINE_WORDS-1:0][`BRISC_XLEN-1:0] words;
    logic [`BRISC_LINE_W/8-1:0][7:0] bytes;
  } line_u;

  // tags a memory request so the fill finds its way back
  typedef enum logic {
    SRC_ICACHE = 1'b0,
    SRC_DCACHE = 1'b1
  } mem_src_e;

endpackage

// File: rtl/dcache.sv
`timescale 1ns/100ps
`include "brisc_cfg.svh"

module dcache (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     d_req,
  input  logic                     d_we,
  input  logic [`BRISC_XLEN/8-1:0] d_be,
  input  logic [`BRISC_ADDR_W-1:0] d_addr,
  input  logic [`BRISC_XLEN-1:0]   d_wdata,
  output logic                     d_valid,
  output logic [`BRISC_XLEN-1:0]   d_rdata,
  output logic                     dc_mreq,
  output logic                     dc_mstore,
  output logic [`BRISC_ADDR_W-1:0] dc_maddr,
  output brisc_pkg::line_u         dc_mdata,
  input  logic                     dc_gnt,
  input  logic                     dc_fill,
  input  brisc_pkg::line_u         dc_fill_data
);

  localparam int BPW = `BRISC_XLEN / 8;
  localparam int BOFF_W = $clog2(BPW);
  localparam int OFF_W = $clog2(`BRISC_LINE_W / 8);
  localparam int WSEL_W = $clog2(`BRISC_LINE_WORDS);
  localparam int IDX_W = $clog2(`BRISC_CACHE_LINES);
  localparam int TAG_W = `BRISC_ADDR_W - OFF_W - IDX_W;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_EVICT = 2'd1;
  localparam logic [1:0] S_REFILL = 2'd2;
  localparam logic [1:0] S_WAIT_FILL = 2'd3;

  logic [1:0] state_q;
  logic [`BRISC_CACHE_LINES-1:0] valid_q;
  logic [`BRISC_CACHE_LINES-1:0] dirty_q;
  logic [TAG_W-1:0] tag_q [`BRISC_CACHE_LINES];
  brisc_pkg::line_u line_q [`BRISC_CACHE_LINES];

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic [WSEL_W-1:0] wsel;
  logic hit;
  logic accept;
  logic fill_in;
  brisc_pkg::line_u base_line;
  brisc_pkg::line_u wr_line;

  assign idx = d_addr[OFF_W +: IDX_W];
  assign tag = d_addr[`BRISC_ADDR_W-1 -: TAG_W];
  assign wsel = d_addr[BOFF_W +: WSEL_W];
  assign hit = valid_q[idx] && (tag_q[idx] == tag);
  assign accept = (state_q == S_IDLE) && d_req && !d_valid;
  assign fill_in = (state_q == S_WAIT_FILL) && dc_fill;

  // eviction goes out with the victim's own tag
  assign dc_mreq = (state_q == S_EVICT) || (state_q == S_REFILL);
  assign dc_mstore = (state_q == S_EVICT);
  assign dc_maddr = (state_q == S_EVICT) ? {tag_q[idx], idx, OFF_W'(0)}
                                         : {d_addr[`BRISC_ADDR_W-1:OFF_W], OFF_W'(0)};
  assign dc_mdata = line_q[idx];

  // store merge works on the fill line or the resident line
  assign base_line = (state_q == S_WAIT_FILL) ? dc_fill_data : line_q[idx];

  always_comb begin
    wr_line = base_line;
    for (int b = 0; b < BPW; b++) begin
      if (d_we && d_be[b]) begin
        wr_line.bytes[wsel * BPW + b] = d_wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      valid_q <= '0;
      dirty_q <= '0;
      d_valid <= 1'b0;
    end else begin
      d_valid <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (accept && hit) begin
            d_valid <= 1'b1;
            if (d_we) begin
              dirty_q[idx] <= 1'b1;
            end
          end else if (accept) begin
            state_q <= (valid_q[idx] && dirty_q[idx]) ? S_EVICT : S_REFILL;
          end
        end
        S_EVICT: begin
          if (dc_gnt) begin
            state_q <= S_REFILL;
          end
        end
        S_REFILL: begin
          if (dc_gnt) begin
            state_q <= S_WAIT_FILL;
          end
        end
        S_WAIT_FILL: begin
          if (dc_fill) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= d_we; // store miss leaves the new line dirty
            d_valid <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((accept && hit) || fill_in) begin
      d_rdata <= base_line.words[wsel];
    end
    if ((accept && hit && d_we) || fill_in) begin
      line_q[idx] <= wr_line;
    end
    if (fill_in) begin
      tag_q[idx] <= tag;
    end
  end

endmodule

// File: rtl/delay_pipe.sv
`timescale 1ns/100ps

module delay_pipe #(
  parameter int depth = 3,
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             en,
  input  logic             clr,
  input  logic [width-1:0] d,
  output logic [width-1:0] q
);

  logic [width-1:0] stage_q [depth];

  always_ff @(posedge clk) begin
    if (!rst_n || clr) begin
      for (int i = 0; i < depth; i++) begin
        stage_q[i] <= '0;
      end
    end else if (en) begin
      stage_q[0] <= d;
      for (int i = 1; i < depth; i++) begin
        stage_q[i] <= stage_q[i-1]; // shift one stage
      end
    end
  end

  assign q = stage_q[depth-1];

endmodule

// File: rtl/icache.sv
`timescale 1ns/100ps
`include "brisc_cfg.svh"

module icache (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     if_req,
  input  logic [`BRISC_ADDR_W-1:0] if_addr,
  output logic                     if_valid,
  output logic [`BRISC_XLEN-1:0]   if_rdata,
  output logic                     ic_mreq,
  output logic [`BRISC_ADDR_W-1:0] ic_maddr,
  input  logic                     ic_gnt,
  input  logic                     ic_fill,
  input  brisc_pkg::line_u         ic_fill_data
);

  localparam int BOFF_W = $clog2(`BRISC_XLEN / 8);
  localparam int OFF_W = $clog2(`BRISC_LINE_W / 8);
  localparam int WSEL_W = $clog2(`BRISC_LINE_WORDS);
  localparam int IDX_W = $clog2(`BRISC_CACHE_LINES);
  localparam int TAG_W = `BRISC_ADDR_W - OFF_W - IDX_W;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_WAIT_GNT = 2'd1;
  localparam logic [1:0] S_WAIT_FILL = 2'd2;

  logic [1:0] state_q;
  logic [`BRISC_CACHE_LINES-1:0] valid_q;
  logic [TAG_W-1:0] tag_q [`BRISC_CACHE_LINES];
  brisc_pkg::line_u line_q [`BRISC_CACHE_LINES];

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic [WSEL_W-1:0] wsel;
  logic hit;
  logic accept;
  logic fill_in;

  // core holds the address until valid
  assign idx = if_addr[OFF_W +: IDX_W];
  assign tag = if_addr[`BRISC_ADDR_W-1 -: TAG_W];
  assign wsel = if_addr[BOFF_W +: WSEL_W];
  assign hit = valid_q[idx] && (tag_q[idx] == tag);
  assign accept = (state_q == S_IDLE) && if_req && !if_valid; // not in the valid cycle
  assign fill_in = (state_q == S_WAIT_FILL) && ic_fill;

  assign ic_mreq = (state_q == S_WAIT_GNT);
  assign ic_maddr = {if_addr[`BRISC_ADDR_W-1:OFF_W], OFF_W'(0)};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      valid_q <= '0;
      if_valid <= 1'b0;
    end else begin
      if_valid <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (accept && hit) begin
            if_valid <= 1'b1;
          end else if (accept) begin
            state_q <= S_WAIT_GNT;
          end
        end
        S_WAIT_GNT: begin
          if (ic_gnt) begin
            state_q <= S_WAIT_FILL;
          end
        end
        S_WAIT_FILL: begin
          if (ic_fill) begin
            valid_q[idx] <= 1'b1;
            if_valid <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept && hit) begin
      if_rdata <= line_q[idx].words[wsel];
    end
    if (fill_in) begin
      line_q[idx] <= ic_fill_data;
      tag_q[idx] <= tag;
      if_rdata <= ic_fill_data.words[wsel]; // critical word straight from fill
    end
  end

endmodule

// File: rtl/main_memory.sv
`timescale 1ns/100ps
`include "brisc_cfg.svh"

module main_memory (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     mem_req,
  input  logic                     mem_store,
  input  brisc_pkg::mem_src_e      mem_src,
  input  logic [`BRISC_ADDR_W-1:0] mem_addr,
  input  brisc_pkg::line_u         mem_data,
  output logic                     fill,
  output brisc_pkg::mem_src_e      fill_src,
  output logic [`BRISC_ADDR_W-1:0] fill_addr,
  output brisc_pkg::line_u         fill_data,
  output logic                     cred_ret
);

  localparam int OFF_W = $clog2(`BRISC_LINE_W / 8);
  localparam int WSEL_W = $clog2(`BRISC_LINE_WORDS);
  localparam int REQ_W = 3 + `BRISC_ADDR_W + `BRISC_LINE_W;
  localparam int RSP_W = 2 + `BRISC_ADDR_W + `BRISC_LINE_W;
  localparam int CRED_W = $clog2(`BRISC_MEM_CREDITS + 1);

  logic [`BRISC_XLEN-1:0] mem_q [`BRISC_MEM_DEPTH];

  logic [REQ_W-1:0] req_q;
  logic [RSP_W-1:0] rsp_q;
  logic rq_req;
  logic rq_store;
  logic rq_src;
  logic rs_src;
  logic [`BRISC_ADDR_W-1:0] rq_addr;
  brisc_pkg::line_u rq_data;
  brisc_pkg::line_u rd_line;
  logic [`BRISC_ADDR_W-OFF_W-1:0] line_idx;
  logic st_apply;
  logic rd_issue;
  logic [CRED_W-1:0] owed_q;

  delay_pipe #(
    .depth(`BRISC_MEM_REQ_DELAY),
    .width(REQ_W)
  ) req_pipe (
    .clk  (clk),
    .rst_n(rst_n),
    .en   (1'b1),
    .clr  (1'b0),
    .d    ({mem_req, mem_store, mem_src, mem_addr, mem_data}),
    .q    (req_q)
  );

  assign {rq_req, rq_store, rq_src, rq_addr, rq_data} = req_q;
  assign line_idx = rq_addr[`BRISC_ADDR_W-1:OFF_W];
  assign st_apply = rq_req & rq_store;
  assign rd_issue = rq_req & ~rq_store;

  // read sees every store applied on an earlier edge
  always_comb begin
    for (int i = 0; i < `BRISC_LINE_WORDS; i++) begin
      rd_line.words[i] = mem_q[{line_idx, WSEL_W'(i)}];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `BRISC_MEM_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (st_apply) begin
      for (int i = 0; i < `BRISC_LINE_WORDS; i++) begin
        mem_q[{line_idx, WSEL_W'(i)}] <= rq_data.words[i];
      end
    end
  end

  delay_pipe #(
    .depth(`BRISC_MEM_RESP_DELAY),
    .width(RSP_W)
  ) resp_pipe (
    .clk  (clk),
    .rst_n(rst_n),
    .en   (1'b1),
    .clr  (1'b0),
    .d    ({rd_issue, rq_src, rq_addr, rd_line}),
    .q    (rsp_q)
  );

  assign {fill, rs_src, fill_addr, fill_data} = rsp_q;
  assign fill_src = brisc_pkg::mem_src_e'(rs_src);

  // a store and a fill can retire in the same cycle, second credit goes out next cycle
  assign cred_ret = st_apply | fill | (owed_q != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      owed_q <= '0;
    end else begin
      owed_q <= owed_q + CRED_W'(st_apply) + CRED_W'(fill) - CRED_W'(cred_ret);
    end
  end

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/100ps
`include "brisc_cfg.svh"

module mem_arbiter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     ic_mreq,
  input  logic [`BRISC_ADDR_W-1:0] ic_maddr,
  output logic                     ic_gnt,
  output logic                     ic_fill,
  output brisc_pkg::line_u         ic_fill_data,
  input  logic                     dc_mreq,
  input  logic                     dc_mstore,
  input  logic [`BRISC_ADDR_W-1:0] dc_maddr,
  input  brisc_pkg::line_u         dc_mdata,
  output logic                     dc_gnt,
  output logic                     dc_fill,
  output brisc_pkg::line_u         dc_fill_data,
  output logic                     mem_req,
  output logic                     mem_store,
  output brisc_pkg::mem_src_e      mem_src,
  output logic [`BRISC_ADDR_W-1:0] mem_addr,
  output brisc_pkg::line_u         mem_data,
  input  logic                     fill,
  input  brisc_pkg::mem_src_e      fill_src,
  input  brisc_pkg::line_u         fill_data,
  input  logic                     cred_ret
);

  localparam int CRED_W = $clog2(`BRISC_MEM_CREDITS + 1);

  brisc_pkg::mem_src_e last_q;
  logic [CRED_W-1:0] cred_q;
  logic has_cred;
  logic pick_dc;

  assign has_cred = (cred_q != '0);
  // dcache wins alone, or on a tie when icache went last
  assign pick_dc = dc_mreq & (~ic_mreq | (last_q == brisc_pkg::SRC_ICACHE));

  assign ic_gnt = has_cred & ic_mreq & ~pick_dc;
  assign dc_gnt = has_cred & pick_dc;

  assign mem_req = ic_gnt | dc_gnt;
  assign mem_store = dc_gnt & dc_mstore; // icache never writes
  assign mem_src = pick_dc ? brisc_pkg::SRC_DCACHE : brisc_pkg::SRC_ICACHE;
  assign mem_addr = pick_dc ? dc_maddr : ic_maddr;
  assign mem_data = dc_mdata;

  // fill routing by source tag
  assign ic_fill = fill & (fill_src == brisc_pkg::SRC_ICACHE);
  assign dc_fill = fill & (fill_src == brisc_pkg::SRC_DCACHE);
  assign ic_fill_data = fill_data;
  assign dc_fill_data = fill_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_q <= brisc_pkg::SRC_DCACHE;
      cred_q <= CRED_W'(`BRISC_MEM_CREDITS);
    end else begin
      if (mem_req) begin
        last_q <= mem_src;
      end
      cred_q <= cred_q - CRED_W'(mem_req) + CRED_W'(cred_ret);
    end
  end

endmodule

// File: rtl/mem_subsys.sv
`timescale 1ns/100ps
`include "brisc_cfg.svh"

module mem_subsys (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     if_req,
  input  logic [`BRISC_ADDR_W-1:0] if_addr,
  output logic                     if_valid,
  output logic [`BRISC_XLEN-1:0]   if_rdata,
  input  logic                     d_req,
  input  logic                     d_we,
  input  logic [`BRISC_XLEN/8-1:0] d_be,
  input  logic [`BRISC_ADDR_W-1:0] d_addr,
  input  logic [`BRISC_XLEN-1:0]   d_wdata,
  output logic                     d_valid,
  output logic [`BRISC_XLEN-1:0]   d_rdata
);

  logic ic_mreq;
  logic [`BRISC_ADDR_W-1:0] ic_maddr;
  logic ic_gnt;
  logic ic_fill;
  brisc_pkg::line_u ic_fill_data;

  logic dc_mreq;
  logic dc_mstore;
  logic [`BRISC_ADDR_W-1:0] dc_maddr;
  brisc_pkg::line_u dc_mdata;
  logic dc_gnt;
  logic dc_fill;
  brisc_pkg::line_u dc_fill_data;

  logic mem_req;
  logic mem_store;
  brisc_pkg::mem_src_e mem_src;
  logic [`BRISC_ADDR_W-1:0] mem_addr;
  brisc_pkg::line_u mem_data;
  logic fill;
  brisc_pkg::mem_src_e fill_src;
  brisc_pkg::line_u fill_data;
  logic cred_ret;

  icache icache_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .if_req      (if_req),
    .if_addr     (if_addr),
    .if_valid    (if_valid),
    .if_rdata    (if_rdata),
    .ic_mreq     (ic_mreq),
    .ic_maddr    (ic_maddr),
    .ic_gnt      (ic_gnt),
    .ic_fill     (ic_fill),
    .ic_fill_data(ic_fill_data)
  );

  dcache dcache_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .d_req       (d_req),
    .d_we        (d_we),
    .d_be        (d_be),
    .d_addr      (d_addr),
    .d_wdata     (d_wdata),
    .d_valid     (d_valid),
    .d_rdata     (d_rdata),
    .dc_mreq     (dc_mreq),
    .dc_mstore   (dc_mstore),
    .dc_maddr    (dc_maddr),
    .dc_mdata    (dc_mdata),
    .dc_gnt      (dc_gnt),
    .dc_fill     (dc_fill),
    .dc_fill_data(dc_fill_data)
  );

  mem_arbiter mem_arbiter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ic_mreq     (ic_mreq),
    .ic_maddr    (ic_maddr),
    .ic_gnt      (ic_gnt),
    .ic_fill     (ic_fill),
    .ic_fill_data(ic_fill_data),
    .dc_mreq     (dc_mreq),
    .dc_mstore   (dc_mstore),
    .dc_maddr    (dc_maddr),
    .dc_mdata    (dc_mdata),
    .dc_gnt      (dc_gnt),
    .dc_fill     (dc_fill),
    .dc_fill_data(dc_fill_data),
    .mem_req     (mem_req),
    .mem_store   (mem_store),
    .mem_src     (mem_src),
    .mem_addr    (mem_addr),
    .mem_data    (mem_data),
    .fill        (fill),
    .fill_src    (fill_src),
    .fill_data   (fill_data),
    .cred_ret    (cred_ret)
  );

  // fill address is routed by tag, not needed past memory
  main_memory main_memory_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_req  (mem_req),
    .mem_store(mem_store),
    .mem_src  (mem_src),
    .mem_addr (mem_addr),
    .mem_data (mem_data),
    .fill     (fill),
    .fill_src (fill_src),
    .fill_addr(),
    .fill_data(fill_data),
    .cred_ret (cred_ret)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module mem_subsys_tb \
  -o mem_subsys_sim

./obj_dir/mem_subsys_sim | tee sim.log

if grep -qx "Verification passed" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi

// File: sources.f
+incdir+include
rtl/brisc_pkg.sv
rtl/delay_pipe.sv
rtl/main_memory.sv
rtl/mem_arbiter.sv
rtl/icache.sv
rtl/dcache.sv
rtl/mem_subsys.sv
dv/mem_subsys_tb.sv
